// File: verilog.f
+incdir+verilog
verilog/exStagePkg.sv
verilog/operandForward.sv
verilog/intAlu.sv
verilog/seqMultiplier.sv
verilog/exStage.sv
dv/exStageChecks.sv
dv/exStageTb.sv

// File: Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exStagePkg.sv
      - verilog/operandForward.sv
      - verilog/intAlu.sv
      - verilog/seqMultiplier.sv
      - verilog/exStage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/exStageChecks.sv
      - dv/exStageTb.sv

// File: dv/exStageTb.sv
`include "exStage_defines.svh"

module exStageTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clock;
	logic rst;
	exStagePkg::word_t regA;
	exStagePkg::word_t regB;
	exStagePkg::fwdBus_t fwd;
	exStagePkg::fwdSel_e selA;
	exStagePkg::fwdSel_e selB;
	logic immSel;
	exStagePkg::aluOp_e aluOp;
	exStagePkg::word_t mulA;
	exStagePkg::word_t mulB;
	logic mulStart;
	logic mulMode;
	exStagePkg::word_t aluResult;
	logic branch;
	exStagePkg::word_t mulResult;
	logic mulBusy;

	logic checkEn;
	exStagePkg::word_t expAlu;
	logic expBranch;
	exStagePkg::word_t expMulResult;
	logic expMulBusy;

	int modelCount; // busy cycles left in the model.
	exStagePkg::word_t modelProduct;
	exStagePkg::word_t heldA;
	exStagePkg::word_t heldB;
	exStagePkg::word_t stimA;
	exStagePkg::word_t stimB;
	int localErrors;
	int testsPassed;
	int testsFailed;
	int seedVal;
	int mark;

	exStage i_dut (
		.clock (clock), .rst (rst), .regA (regA), .regB (regB), .fwd (fwd),
		.selA (selA), .selB (selB), .immSel (immSel), .aluOp (aluOp),
		.mulA (mulA), .mulB (mulB), .mulStart (mulStart), .mulMode (mulMode),
		.aluResult (aluResult), .branch (branch), .mulResult (mulResult), .mulBusy (mulBusy)
	);

	exStageChecks i_checks (
		.clock (clock), .checkEn (checkEn), .aluResult (aluResult), .expAlu (expAlu),
		.branch (branch), .expBranch (expBranch), .mulResult (mulResult),
		.expMulResult (expMulResult), .mulBusy (mulBusy), .expMulBusy (expMulBusy)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ****************************************
	// reference model
	// ****************************************
	function automatic exStagePkg::word_t pickOperand(input logic [1:0] sel,
		input exStagePkg::word_t regVal);
		if (sel == 2'd1) return fwd.exMem;
		if (sel == 2'd2) return fwd.memWb;
		return regVal;
	endfunction

	function automatic exStagePkg::word_t aluModel(input exStagePkg::word_t a,
		input exStagePkg::word_t b, input logic [3:0] op);
		logic [63:0] ext;
		ext = {{32{a[31]}}, a}; // sign-extended copy for sra.
		case (op)
			4'd0: return (b < 32) ? a << b[4:0] : 32'h0;
			4'd1: return (b < 32) ? a >> b[4:0] : 32'h0;
			4'd2: return (b < 32) ? 32'(ext >> b[4:0]) : ext[63:32];
			4'd3: return a + b;
			4'd4: return a - b;
			4'd5: return a | b;
			4'd6: return a & b;
			4'd7: return a ^ b;
			4'd8: return (a == b) ? 32'd1 : 32'd0;
			4'd9: return (a != b) ? 32'd1 : 32'd0;
			4'd10: return (a < b) ? 32'd1 : 32'd0;
			4'd11: return (a > b) ? 32'd1 : 32'd0;
			4'd12: return (a <= b) ? 32'd1 : 32'd0;
			4'd13: return (a >= b) ? 32'd1 : 32'd0;
			4'd14: return {b[15:0], 16'h0};
			default: return 32'h0;
		endcase
	endfunction

	// wait one edge, then apply what that edge did to the multiplier.
	task automatic tick();
		@(posedge clock);
		#5;
		if (rst) begin
			modelCount = 0;
			modelProduct = '0;
		end else if (mulStart && modelCount == 0) begin
			modelCount = `EX_MUL_STEPS;
			heldA = mulA;
			heldB = mulB;
		end else if (modelCount != 0) begin
			modelCount--;
			if (modelCount == 0) modelProduct = heldA * heldB;
		end
	endtask

	task automatic predict();
		exStagePkg::word_t a;
		exStagePkg::word_t b;
		a = pickOperand(selA, regA);
		b = immSel ? regB : pickOperand(selB, regB);
		expAlu = aluModel(a, b, aluOp);
		expBranch = expAlu[0];
		expMulBusy = (modelCount != 0);
		expMulResult = (mulMode && modelProduct[31]) ? -modelProduct : modelProduct;
	endtask

	task automatic advance();
		tick();
		predict();
	endtask

	function automatic int errorsSoFar();
		return i_checks.errorCount + localErrors;
	endfunction

	task automatic finishTest(input string name, input int startMark);
		advance(); // lets the last expectation get checked.
		if (errorsSoFar() == startMark) begin
			testsPassed++;
			$display("test %s passed", name);
		end else begin
			testsFailed++;
			$display("test %s failed", name);
		end
	endtask

	// ****************************************
	// multiply with an optional second start
	// ****************************************
	task automatic runMultiply(input exStagePkg::word_t a, input exStagePkg::word_t b,
		input int restartAt, input exStagePkg::word_t a2, input exStagePkg::word_t b2);
		int busyCycles;
		int waited;
		tick();
		mulA = a;
		mulB = b;
		mulStart = 1'b1;
		predict();
		tick();
		mulStart = 1'b0;
		predict();
		busyCycles = 0;
		waited = 0;
		while (mulBusy === 1'b1) begin
			busyCycles++;
			if (busyCycles == restartAt) begin
				mulA = a2;
				mulB = b2;
				mulStart = 1'b1;
				predict();
			end
			tick();
			mulStart = 1'b0;
			predict();
			waited++;
			if (waited > 40) begin
				$display("timeout at %0t, mulBusy stayed high for 40 cycles", $time);
				localErrors++;
				break;
			end
		end
		assert (busyCycles == `EX_MUL_STEPS) else begin
			$display("error %0t mulBusy cycles expected %0d actual %0d", $time,
				`EX_MUL_STEPS, busyCycles);
			localErrors++;
		end
	endtask

	task automatic toggleMode(input int count);
		for (int i = 0; i < count; i++) begin
			tick();
			mulMode = ~mulMode;
			predict();
		end
	endtask

	// ****************************************
	// tests
	// ****************************************
	initial begin
		rst = 1'b1;
		regA = '0;
		regB = '0;
		fwd = '0;
		selA = exStagePkg::fwdNone;
		selB = exStagePkg::fwdNone;
		immSel = 1'b0;
		aluOp = exStagePkg::opAdd;
		mulA = '0;
		mulB = '0;
		mulStart = 1'b0;
		mulMode = 1'b0;
		checkEn = 1'b0;
		modelCount = 0;
		modelProduct = '0;
		localErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		seedVal = 32'h2e23a699;
		void'($urandom(seedVal));
		predict();

		mark = errorsSoFar();
		for (int i = 0; i < 5; i++) begin
			tick();
			checkEn = 1'b1;
			predict();
		end
		rst = 1'b0;
		predict();
		assert (mulBusy === 1'b0) else begin
			$display("error %0t mulBusy expected 0 actual %b", $time, mulBusy);
			localErrors++;
		end
		assert (mulResult === '0) else begin
			$display("error %0t mulResult expected 0 actual %h", $time, mulResult);
			localErrors++;
		end
		finishTest("reset", mark);

		mark = errorsSoFar();
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				for (int m = 0; m < 4; m++) begin
					tick();
					regA = $urandom;
					regB = $urandom;
					fwd.exMem = $urandom;
					fwd.memWb = $urandom;
					selA = exStagePkg::fwdSel_e'(s[1:0]); // code 3 included.
					selB = exStagePkg::fwdSel_e'(t[1:0]);
					immSel = m[0];
					aluOp = m[1] ? exStagePkg::opOr : exStagePkg::opAdd;
					predict();
				end
			end
		end
		finishTest("forwarding", mark);

		mark = errorsSoFar();
		selA = exStagePkg::fwdNone;
		selB = exStagePkg::fwdNone;
		immSel = 1'b0;
		for (int op = 0; op < 16; op++) begin
			for (int k = 0; k < 7; k++) begin
				tick();
				stimA = $urandom;
				stimB = $urandom;
				case (k)
					0: stimB = 32'd0;
					1: begin
						stimB = 32'd31;
						stimA[31] = 1'b1; // sign fill below 32 too.
					end
					2: begin
						stimB = 32'd32;
						stimA[31] = 1'b1; // sign fill for sra.
					end
					3: stimB = stimB | 32'h0001_0000;
					4: stimB = stimA;
					5: begin
						stimB = stimB | 32'h1;
						stimA = stimB >> 1; // a below b.
					end
					default: begin
						stimA = stimA | 32'h8000_0000;
						stimB = stimA >> 1;
					end
				endcase
				regA = stimA;
				regB = stimB;
				aluOp = exStagePkg::aluOp_e'(op[3:0]);
				predict();
			end
		end
		finishTest("alu operations", mark);

		mark = errorsSoFar();
		mulMode = 1'b0;
		for (int i = 0; i < 3; i++) runMultiply($urandom, $urandom, 0, '0, '0);
		runMultiply('0, $urandom, 0, '0, '0);
		runMultiply($urandom, '0, 0, '0, '0);
		runMultiply('1, '1, 0, '0, '0);
		finishTest("multiply latency", mark);

		mark = errorsSoFar();
		runMultiply($urandom, $urandom, 5, $urandom, $urandom);
		runMultiply($urandom, $urandom, 32, $urandom, $urandom); // start on the last step.
		finishTest("busy behavior", mark);

		mark = errorsSoFar();
		runMultiply(32'd1, $urandom | 32'h8000_0000, 0, '0, '0);
		toggleMode(3);
		// old negative product shows negated during this one.
		runMultiply(32'd3, $urandom & 32'h0fff_ffff, 0, '0, '0);
		toggleMode(3);
		runMultiply($urandom, $urandom, 0, '0, '0);
		toggleMode(4);
		finishTest("magnitude mode", mark);

		advance();
		$display("tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && errorsSoFar() == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: dv/exStageChecks.sv
module exStageChecks (
	input logic              clock,
	input logic              checkEn,
	input exStagePkg::word_t aluResult,
	input exStagePkg::word_t expAlu,
	input logic              branch,
	input logic              expBranch,
	input exStagePkg::word_t mulResult,
	input exStagePkg::word_t expMulResult,
	input logic              mulBusy,
	input logic              expMulBusy
);
	timeunit 1ns;
	timeprecision 1ps;

	int errorCount;

	initial errorCount = 0;

	// ****************************************
	// alu and branch
	// ****************************************
	// expectations were set one cycle ago, so they are settled here.
	always @(posedge clock) begin
		if (checkEn) begin
			assert (aluResult === expAlu) else begin
				$display("error %0t aluResult expected %h actual %h", $time, expAlu, aluResult);
				errorCount++;
			end
			assert (branch === expBranch) else begin
				$display("error %0t branch expected %b actual %b", $time, expBranch, branch);
				errorCount++;
			end
		end
	end

	// ****************************************
	// multiplier
	// ****************************************
	always @(posedge clock) begin
		if (checkEn) begin
			assert (mulBusy === expMulBusy) else begin
				$display("error %0t mulBusy expected %b actual %b", $time, expMulBusy, mulBusy);
				errorCount++;
			end
			assert (mulResult === expMulResult) else begin
				$display("error %0t mulResult expected %h actual %h", $time, expMulResult,
					mulResult);
				errorCount++;
			end
		end
	end

endmodule

// File: verilog/exStage.sv
module exStage (
	input  logic                clock,
	input  logic                rst,
	input  exStagePkg::word_t   regA,
	input  exStagePkg::word_t   regB,
	input  exStagePkg::fwdBus_t fwd,
	input  exStagePkg::fwdSel_e selA,
	input  exStagePkg::fwdSel_e selB,
	input  logic                immSel,
	input  exStagePkg::aluOp_e  aluOp,
	input  exStagePkg::word_t   mulA,
	input  exStagePkg::word_t   mulB,
	input  logic                mulStart,
	input  logic                mulMode,
	output exStagePkg::word_t   aluResult,
	output logic                branch,
	output exStagePkg::word_t   mulResult,
	output logic                mulBusy
);

	exStagePkg::word_t opA;
	exStagePkg::word_t opB;

	// bypass network feeds the alu directly.
	operandForward i_forward (
		.regA   (regA),
		.regB   (regB),
		.fwd    (fwd),
		.selA   (selA),
		.selB   (selB),
		.immSel (immSel),
		.opA    (opA),
		.opB    (opB)
	);

	intAlu i_alu (
		.opA       (opA),
		.opB       (opB),
		.aluOp     (aluOp),
		.aluResult (aluResult),
		.branch    (branch)
	);

	// multiplier has its own operands. pipeline stalls on mulBusy.
	seqMultiplier i_mul (
		.clock     (clock),
		.rst       (rst),
		.mulStart  (mulStart),
		.mulA      (mulA),
		.mulB      (mulB),
		.mulMode   (mulMode),
		.mulBusy   (mulBusy),
		.mulResult (mulResult)
	);

endmodule

// File: verilog/seqMultiplier.sv
`include "exStage_defines.svh"

module seqMultiplier (
	input  logic              clock,
	input  logic              rst,
	input  logic              mulStart,
	input  exStagePkg::word_t mulA,
	input  exStagePkg::word_t mulB,
	input  logic              mulMode,
	output logic              mulBusy,
	output exStagePkg::word_t mulResult
);

	localparam int CntW = $clog2(`EX_MUL_STEPS + 1);

	logic [CntW-1:0] stepCount;
	exStagePkg::word_t mcand; // held for the whole multiply.
	exStagePkg::word_t mplier; // shifts left, msb is the live bit.
	exStagePkg::word_t acc;
	exStagePkg::word_t accNext;
	exStagePkg::word_t product;
	logic accept;
	logic lastStep;

	// ****************************************
	// control
	// ****************************************
	assign mulBusy = (stepCount != '0);
	assign accept = mulStart && !mulBusy; // starts during busy are dropped.
	assign lastStep = (stepCount == CntW'(1));

	always_ff @(posedge clock) begin
		if (rst) begin
			stepCount <= '0;
			product <= '0;
		end else if (accept) begin
			stepCount <= CntW'(`EX_MUL_STEPS);
		end else if (mulBusy) begin
			stepCount <= stepCount - 1'b1;
			// old product stays up until the final step lands.
			if (lastStep) begin
				product <= accNext;
			end
		end
	end

	// ****************************************
	// shift-add datapath
	// ****************************************
	// partial products go in from the top multiplier bit down.
	// doubling the accumulator each step lines each one up,
	// and bits past the word width drop out.
	assign accNext = {acc[`EX_WORD_W-2:0], 1'b0}
		+ (mplier[`EX_WORD_W-1] ? mcand : '0);

	always_ff @(posedge clock) begin
		if (accept) begin
			mcand <= mulB;
			mplier <= mulA;
			acc <= '0;
		end else if (mulBusy) begin
			mplier <= {mplier[`EX_WORD_W-2:0], 1'b0};
			acc <= accNext;
		end
	end

	// ****************************************
	// magnitude output
	// ****************************************
	always_comb begin
		if (mulMode && product[`EX_WORD_W-1]) begin
			mulResult = ~product + 1'b1; // negate negative products.
		end else begin
			mulResult = product;
		end
	end

endmodule

// File: verilog/intAlu.sv
`include "exStage_defines.svh"

module intAlu (
	input  exStagePkg::word_t  opA,
	input  exStagePkg::word_t  opB,
	input  exStagePkg::aluOp_e aluOp,
	output exStagePkg::word_t  aluResult,
	output logic               branch
);

	logic [`EX_SHAMT_W-1:0] shamt;
	logic bigShift;
	exStagePkg::word_t sllOut;
	exStagePkg::word_t srlOut;
	exStagePkg::word_t sraOut;
	exStagePkg::word_t lhiOut;
	logic isEq;
	logic isLt;

	// ****************************************
	// shifter
	// ****************************************
	// the whole of opB is the amount; anything past the low bits saturates.
	assign shamt = opB[`EX_SHAMT_W-1:0];
	assign bigShift = |opB[`EX_WORD_W-1:`EX_SHAMT_W];

	assign sllOut = bigShift ? '0 : (opA << shamt);
	assign srlOut = bigShift ? '0 : (opA >> shamt);
	// a saturated amount leaves only sign bits.
	assign sraOut = $signed(opA) >>> (bigShift ? `EX_SHAMT_W'(`EX_WORD_W-1) : shamt);

	// low half of opB moved up.
	assign lhiOut = {opB[`EX_WORD_W/2-1:0], {(`EX_WORD_W/2){1'b0}}};

	// words are unsigned, so these compare unsigned.
	assign isEq = (opA == opB);
	assign isLt = (opA < opB);

	// ****************************************
	// result select
	// ****************************************
	always_comb begin
		case (aluOp)
			exStagePkg::opSll: aluResult = sllOut;
			exStagePkg::opSrl: aluResult = srlOut;
			exStagePkg::opSra: aluResult = sraOut;
			exStagePkg::opAdd: aluResult = opA + opB;
			exStagePkg::opSub: aluResult = opA - opB;
			exStagePkg::opOr:  aluResult = opA | opB;
			exStagePkg::opAnd: aluResult = opA & opB;
			exStagePkg::opXor: aluResult = opA ^ opB;
			exStagePkg::opSeq: aluResult = exStagePkg::word_t'(isEq);
			exStagePkg::opSne: aluResult = exStagePkg::word_t'(!isEq);
			exStagePkg::opSlt: aluResult = exStagePkg::word_t'(isLt);
			exStagePkg::opSgt: aluResult = exStagePkg::word_t'(!isLt && !isEq);
			exStagePkg::opSle: aluResult = exStagePkg::word_t'(isLt || isEq);
			exStagePkg::opSge: aluResult = exStagePkg::word_t'(!isLt);
			exStagePkg::opLhi: aluResult = lhiOut;
			default: aluResult = '0; // code 15.
		endcase
	end

	// set-compares leave their answer in bit 0.
	assign branch = aluResult[0];

endmodule

// File: verilog/operandForward.sv
module operandForward (
	input  exStagePkg::word_t   regA,
	input  exStagePkg::word_t   regB,
	input  exStagePkg::fwdBus_t fwd,
	input  exStagePkg::fwdSel_e selA,
	input  exStagePkg::fwdSel_e selB,
	input  logic                immSel,
	output exStagePkg::word_t   opA,
	output exStagePkg::word_t   opB
);

	// hazard bypass for one operand.
	function automatic exStagePkg::word_t pickSource(
		input exStagePkg::fwdSel_e sel,
		input exStagePkg::word_t   regVal,
		input exStagePkg::fwdBus_t bus
	);
		case (sel)
			exStagePkg::fwdExMem: return bus.exMem;
			exStagePkg::fwdMemWb: return bus.memWb;
			default: return regVal; // none and code 3.
		endcase
	endfunction

	assign opA = pickSource(selA, regA, fwd);

	// an immediate arrives on regB and skips the bypass.
	always_comb begin
		if (immSel) begin
			opB = regB;
		end else begin
			opB = pickSource(selB, regB, fwd);
		end
	end

endmodule

// File: verilog/exStagePkg.sv
`include "exStage_defines.svh"

package exStagePkg;

	// ****************************************
	// data word and forwarding
	// ****************************************
	typedef logic [`EX_WORD_W-1:0] word_t;

	typedef enum logic [1:0] {
		fwdNone = `EX_FWD_NONE,
		fwdExMem = `EX_FWD_EXMEM,
		fwdMemWb = `EX_FWD_MEMWB
	} fwdSel_e;

	// results coming back from the later stages.
	typedef struct packed {
		word_t exMem;
		word_t memWb;
	} fwdBus_t;

	// ****************************************
	// alu operations
	// ****************************************
	typedef enum logic [3:0] {
		opSll = 4'd0,
		opSrl, opSra,
		opAdd, opSub, opOr, opAnd, opXor,
		opSeq, opSne, opSlt, opSgt, opSle, opSge, // unsigned compares.
		opLhi = 4'd14
	} aluOp_e;

endpackage

// File: verilog/exStage_defines.svh
`ifndef EX_STAGE_DEFINES_SVH
`define EX_STAGE_DEFINES_SVH

// ****************************************
// datapath widths
// ****************************************
`define EX_WORD_W 32
// amount bits the barrel shifter really uses.
`define EX_SHAMT_W 5

// one partial product per step, so steps equal the word width.
`define EX_MUL_STEPS 32

// ****************************************
// forward select codes
// ****************************************
`define EX_FWD_NONE 2'd0
`define EX_FWD_EXMEM 2'd1
`define EX_FWD_MEMWB 2'd2
// code 3 is unused and acts as none.

`endif
